// File: test/backend_input.txt
# op width rd result store_data link expected, all hex
# op 0 alu 1 load 2 store 3 jump, expected is the rd value or the jump target
0 0 01 12345678 00000000 00000000 12345678
0 0 02 deadbeef 00000000 00000000 deadbeef
0 0 00 ffffffff 00000000 00000000 00000000
0 0 1f 80000001 00000000 00000000 80000001
2 2 00 00000040 cafef00d 00000000 00000000
1 2 03 00000040 00000000 00000000 cafef00d
2 0 00 00000041 000000a5 00000000 00000000
1 2 04 00000040 00000000 00000000 cafea50d
1 0 05 00000040 00000000 00000000 0000000d
1 4 15 00000040 00000000 00000000 0000000d
1 0 06 00000041 00000000 00000000 ffffffa5
1 4 07 00000041 00000000 00000000 000000a5
1 0 08 00000042 00000000 00000000 fffffffe
1 4 09 00000043 00000000 00000000 000000ca
1 0 0a 00000043 00000000 00000000 ffffffca
1 1 0b 00000040 00000000 00000000 ffffa50d
1 5 0c 00000040 00000000 00000000 0000a50d
1 1 0d 00000042 00000000 00000000 ffffcafe
1 5 0e 00000042 00000000 00000000 0000cafe
2 2 00 00000080 11223344 00000000 00000000
2 1 00 00000082 0000789a 00000000 00000000
1 2 0f 00000080 00000000 00000000 789a3344
1 1 10 00000082 00000000 00000000 0000789a
2 0 00 00000080 00000080 00000000 00000000
1 0 11 00000080 00000000 00000000 ffffff80
1 4 12 00000082 00000000 00000000 0000009a
1 0 14 00000083 00000000 00000000 00000078
3 0 01 00000200 00000000 00000104 00000200
0 0 13 00000007 00000000 00000000 00000007
3 0 00 00000300 00000000 00000008 00000300

// File: verilog.f
common/rvga_types_pkg.sv
common/rvga_mem_pkg.sv
source/memory_stage.sv
source/writeback_stage.sv
source/register_file.sv
source/data_ram.sv
source/rvga_backend.sv
test/backend_chk.sv
test/backend_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the backend testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module backend_tb -f verilog.f &&
./obj_dir/Vbackend_tb | tee /dev/stderr | grep -q "^Result: PASSED$" &&
echo "backend simulation passed" ||
{ echo "backend simulation failed"; exit 1; }

// File: test/backend_tb.sv
`default_nettype none

module backend_tb;

  import rvga_types_pkg::*;
  import rvga_mem_pkg::*;

  localparam int unsigned RAM_WORDS         = 256;
  localparam int unsigned WAIT_STATES       = 1;
  localparam int unsigned ADR_W             = $clog2(RAM_WORDS);
  localparam int unsigned CLK_PERIOD        = 20;
  localparam int unsigned RESET_CYCLES      = 8;
  localparam int unsigned CYCLES_PER_RECORD = 40;
  localparam string       INPUT_FILE        = "test/backend_input.txt";

  logic      clk;
  logic      rst_n;
  logic      ex_valid;
  rvga_op    ex_op;
  rvga_width ex_width;
  rvga_reg   ex_rd;
  rvga_word  ex_result;
  rvga_word  ex_store_data;
  rvga_word  ex_link;
  logic      ex_ready;
  rvga_reg   rs1;
  rvga_reg   rs2;
  rvga_word  rs1_data;
  rvga_word  rs2_data;
  logic      pc_w_v;
  rvga_word  pc_target;

  // records from the input file, one entry per column
  logic [31:0] rec_op [$];
  logic [31:0] rec_width [$];
  logic [31:0] rec_rd [$];
  logic [31:0] rec_result [$];
  logic [31:0] rec_store [$];
  logic [31:0] rec_link [$];
  logic [31:0] rec_exp [$];
  int          rec_count;
  bit          records_loaded;

  // reference state of the register file and the data RAM
  logic [31:0] ref_regs [32];
  logic [31:0] ref_mem [RAM_WORDS];

  int unsigned rand_state;
  int unsigned pulse_count;
  int unsigned total_pulses;
  int unsigned jumps_seen;
  rvga_word    pulse_target;

  rvga_backend #(
    .RAM_WORDS   (RAM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) UUT (
    .clk             (clk),
    .rst_n_i         (rst_n),
    .ex_valid_i      (ex_valid),
    .ex_op_i         (ex_op),
    .ex_width_i      (ex_width),
    .ex_rd_i         (ex_rd),
    .ex_result_i     (ex_result),
    .ex_store_data_i (ex_store_data),
    .ex_link_i       (ex_link),
    .ex_ready_o      (ex_ready),
    .rs1_i           (rs1),
    .rs2_i           (rs2),
    .rs1_data_o      (rs1_data),
    .rs2_data_o      (rs2_data),
    .pc_w_v_o        (pc_w_v),
    .pc_target_o     (pc_target)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // redirect pulses are counted on falling edges where they are stable
  always @(negedge clk) begin
    if (rst_n && pc_w_v) begin
      pulse_count  = pulse_count + 1;
      total_pulses = total_pulses + 1;
      pulse_target = pc_target;
    end
  end

  ////////////////////////////////////////
  // helpers and reference model
  ////////////////////////////////////////

  function automatic int unsigned next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s: actual %h expected %h", $time, name, actual, expected);
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  function automatic void model_store(input logic [31:0] addr, input rvga_width width,
                                      input logic [31:0] data);
    logic [31:0] word;
    word = ref_mem[addr[ADR_W+1:2]];
    case (width)
      W_BYTE, W_BYTE_U: word[8*addr[1:0] +: 8] = data[7:0];
      W_HALF, W_HALF_U: word[16*addr[1] +: 16] = data[15:0];
      default:          word = data;
    endcase
    ref_mem[addr[ADR_W+1:2]] = word;
  endfunction

  function automatic logic [31:0] model_load(input logic [31:0] addr, input rvga_width width);
    logic [31:0] word;
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;
    word      = ref_mem[addr[ADR_W+1:2]];
    lane_byte = word[8*addr[1:0] +: 8];
    lane_half = word[16*addr[1] +: 16];
    case (width)
      W_BYTE:   return {{24{lane_byte[7]}}, lane_byte};
      W_BYTE_U: return {24'd0, lane_byte};
      W_HALF:   return {{16{lane_half[15]}}, lane_half};
      W_HALF_U: return {16'd0, lane_half};
      default:  return word;
    endcase
  endfunction

  task automatic load_records();
    int               fd;
    int               n;
    int               got;
    bit               stop;
    logic [31:0]      f_op;
    logic [31:0]      f_width;
    logic [31:0]      f_rd;
    logic [31:0]      f_result;
    logic [31:0]      f_store;
    logic [31:0]      f_link;
    logic [31:0]      f_exp;
    logic [8*200-1:0] skip_line;
    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0) begin
      $display("could not open the stimulus file %s", INPUT_FILE);
      $display("Result: FAILED");
      $fatal(1);
    end
    stop = 1'b0;
    while (!stop) begin
      n = $fscanf(fd, "%h %h %h %h %h %h %h\n",
                  f_op, f_width, f_rd, f_result, f_store, f_link, f_exp);
      if (n == 7) begin
        rec_op.push_back(f_op);
        rec_width.push_back(f_width);
        rec_rd.push_back(f_rd);
        rec_result.push_back(f_result);
        rec_store.push_back(f_store);
        rec_link.push_back(f_link);
        rec_exp.push_back(f_exp);
      end else if (n < 0 || $feof(fd)) begin
        stop = 1'b1;
      end else if (n == 0) begin
        // a comment line, skip the rest of it
        got = $fgets(skip_line, fd);
        stop = (got == 0);
      end else begin
        $display("record %0d in the stimulus file is incomplete", rec_op.size());
        $display("Result: FAILED");
        $fatal(1);
      end
    end
    $fclose(fd);
    rec_count = rec_op.size();
  endtask

  ////////////////////////////////////////
  // one operation through the back end
  ////////////////////////////////////////

  task automatic run_record(input int idx);
    rvga_op      op;
    rvga_width   width;
    rvga_reg     rd;
    logic [31:0] result;
    logic [31:0] store_data;
    logic [31:0] link;
    logic [31:0] exp_rd;
    int unsigned busy;
    op         = rvga_op'(rec_op[idx][1:0]);
    width      = rvga_width'(rec_width[idx][2:0]);
    rd         = rec_rd[idx][4:0];
    result     = rec_result[idx];
    store_data = rec_store[idx];
    link       = rec_link[idx];

    case (op)
      OP_ALU:   ref_regs[rd] = result;
      OP_LOAD:  ref_regs[rd] = model_load(result, width);
      OP_STORE: model_store(result, width, store_data);
      default: begin
        ref_regs[rd] = link;
        jumps_seen++;
      end
    endcase
    ref_regs[0] = '0;
    exp_rd = ref_regs[rd];
    if (op == OP_JUMP) begin
      check_value("file jump target", rec_exp[idx], result);
    end else begin
      check_value("file rd value", rec_exp[idx], exp_rd);
    end

    ex_op         = op;
    ex_width      = width;
    ex_rd         = rd;
    ex_result     = result;
    ex_store_data = store_data;
    ex_link       = link;
    ex_valid      = 1'b1;
    rs1           = rd;
    rs2           = rd;
    pulse_count   = 0;
    // ready seen high on a falling edge means the transfer happens at the next rising edge
    while (!ex_ready) @(negedge clk);
    @(negedge clk);
    ex_valid = 1'b0;

    if (op == OP_LOAD || op == OP_STORE) begin
      check_value("ex_ready_o in bus cycle", {31'd0, ex_ready}, 32'd0);
      // a bubble alu write to x0 waits behind the bus cycle with valid held high
      ex_op    = OP_ALU;
      ex_rd    = '0;
      ex_valid = 1'b1;
      busy = 0;
      while (!ex_ready) begin
        busy++;
        @(negedge clk);
      end
      check_value("ex_ready_o low cycles", busy, WAIT_STATES + 2);
      @(negedge clk);
      ex_valid = 1'b0;
    end

    repeat (2) @(negedge clk);
    check_value("rs1_data_o", rs1_data, exp_rd);
    check_value("rs2_data_o", rs2_data, exp_rd);
    @(negedge clk);
    check_value("pc_w_v_o pulses", pulse_count, (op == OP_JUMP) ? 32'd1 : 32'd0);
    if (op == OP_JUMP) begin
      check_value("pc_target_o", pulse_target, result);
    end
  endtask

  initial begin : watchdog
    int unsigned limit;
    wait (records_loaded);
    limit = rec_count * CYCLES_PER_RECORD + RESET_CYCLES;
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("Result: FAILED");
    $fatal(1);
  end

  initial begin : stimulus
    int unsigned idle;
    clk           = 1'b0;
    rst_n         = 1'b0;
    ex_valid      = 1'b0;
    ex_op         = OP_ALU;
    ex_width      = W_WORD;
    ex_rd         = '0;
    ex_result     = '0;
    ex_store_data = '0;
    ex_link       = '0;
    rs1           = '0;
    rs2           = '0;
    rand_state    = 50;
    pulse_count   = 0;
    total_pulses  = 0;
    jumps_seen    = 0;
    for (int r = 0; r < 32; r++) begin
      ref_regs[r] = '0;
    end
    load_records();
    records_loaded = 1'b1;

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("ex_ready_o after reset", {31'd0, ex_ready}, 32'd1);
    check_value("pc_w_v_o after reset", {31'd0, pc_w_v}, 32'd0);

    for (int i = 0; i < rec_count; i++) begin
      idle = (next_rand() >> 16) % 3;
      repeat (idle) @(negedge clk);
      run_record(i);
    end
    check_value("pc_w_v_o pulses in run", total_pulses, jumps_seen);

    if (rec_count > 0) begin
      $display("Result: PASSED");
    end else begin
      $display("no records were run from %s", INPUT_FILE);
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule : backend_tb

`default_nettype wire

// File: test/backend_chk.sv
`default_nettype none

module backend_chk (
  input wire logic                     clk,
  input wire logic                     rst_n_i,
  input wire logic                     valid_i,
  input wire logic                     ready_i,
  input wire rvga_mem_pkg::rvga_op     op_i,
  input wire rvga_mem_pkg::rvga_width  width_i,
  input wire rvga_types_pkg::rvga_reg  rd_i,
  input wire rvga_types_pkg::rvga_word result_i,
  input wire rvga_types_pkg::rvga_word store_data_i,
  input wire rvga_types_pkg::rvga_word link_i,
  input wire logic                     cyc_i,
  input wire logic                     stb_i,
  input wire logic                     ack_i
);

  import rvga_mem_pkg::*;

  ////////////////////////////////////////
  // wishbone classic rules
  ////////////////////////////////////////

  // cyc and stb stay up until the slave answers
  bus_held_until_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
    (cyc_i && !ack_i) |=> (cyc_i && stb_i))
    else $error("wishbone cyc or stb dropped before ack");

  ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n_i) ack_i |-> stb_i)
    else $error("wishbone ack arrived without stb");

  // execute is stalled for the whole bus cycle
  bus_opens_on_access: assert property (@(posedge clk) disable iff (!rst_n_i)
    (valid_i && ready_i && (op_i == OP_LOAD || op_i == OP_STORE)) |=> (cyc_i && !ready_i))
    else $error("an accepted load or store did not open a stalled bus cycle");

  release_after_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
    ack_i |=> (!cyc_i && !stb_i && ready_i))
    else $error("the bus cycle did not close right after ack");

  hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n_i)
    (valid_i && !ready_i) |=> (valid_i && $stable(op_i) && $stable(width_i) &&
                               $stable(rd_i) && $stable(result_i) &&
                               $stable(store_data_i) && $stable(link_i)))
    else $error("execute fields changed while the stage was stalled");

endmodule : backend_chk

bind memory_stage backend_chk u_backend_chk (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .valid_i      (ex_valid_i),
  .ready_i      (ex_ready_o),
  .op_i         (ex_op_i),
  .width_i      (ex_width_i),
  .rd_i         (ex_rd_i),
  .result_i     (ex_result_i),
  .store_data_i (ex_store_data_i),
  .link_i       (ex_link_i),
  .cyc_i        (wb_cyc_o),
  .stb_i        (wb_stb_o),
  .ack_i        (wb_ack_i)
);

`default_nettype wire

// File: source/rvga_backend.sv
`default_nettype none

module rvga_backend #(
  parameter int unsigned RAM_WORDS   = 256,
  parameter int unsigned WAIT_STATES = 1
) (
  input  wire logic                     clk,
  input  wire logic                     rst_n_i,

  input  wire logic                     ex_valid_i,
  input  wire rvga_mem_pkg::rvga_op     ex_op_i,
  input  wire rvga_mem_pkg::rvga_width  ex_width_i,
  input  wire rvga_types_pkg::rvga_reg  ex_rd_i,
  input  wire rvga_types_pkg::rvga_word ex_result_i,
  input  wire rvga_types_pkg::rvga_word ex_store_data_i,
  input  wire rvga_types_pkg::rvga_word ex_link_i,
  output logic                          ex_ready_o,

  input  wire rvga_types_pkg::rvga_reg  rs1_i,
  input  wire rvga_types_pkg::rvga_reg  rs2_i,
  output rvga_types_pkg::rvga_word      rs1_data_o,
  output rvga_types_pkg::rvga_word      rs2_data_o,

  output logic                          pc_w_v_o,
  output rvga_types_pkg::rvga_word      pc_target_o
);

  import rvga_types_pkg::*;

  ////////////////////////////////////////
  // memory stage to writeback
  ////////////////////////////////////////

  logic     mem_rd_w_v;
  logic     mem_pc_w_v;
  rvga_reg  mem_rd;
  rvga_word mem_result;
  rvga_word mem_target;

  // writeback to register file
  logic     wb_rd_w_v;
  rvga_reg  wb_rd;
  rvga_word wb_rd_data;

  ////////////////////////////////////////
  // wishbone between memory stage and RAM
  ////////////////////////////////////////

  logic                         bus_cyc;
  logic                         bus_stb;
  logic                         bus_we;
  logic [$clog2(RAM_WORDS)-1:0] bus_adr;
  logic [3:0]                   bus_sel;
  rvga_word                     bus_dat_w;
  logic                         bus_ack;
  rvga_word                     bus_dat_r;

  memory_stage #(
    .RAM_WORDS (RAM_WORDS)
  ) u_memory_stage (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .ex_valid_i      (ex_valid_i),
    .ex_op_i         (ex_op_i),
    .ex_width_i      (ex_width_i),
    .ex_rd_i         (ex_rd_i),
    .ex_result_i     (ex_result_i),
    .ex_store_data_i (ex_store_data_i),
    .ex_link_i       (ex_link_i),
    .ex_ready_o      (ex_ready_o),
    .wb_cyc_o        (bus_cyc),
    .wb_stb_o        (bus_stb),
    .wb_we_o         (bus_we),
    .wb_adr_o        (bus_adr),
    .wb_sel_o        (bus_sel),
    .wb_dat_o        (bus_dat_w),
    .wb_ack_i        (bus_ack),
    .wb_dat_i        (bus_dat_r),
    .rd_w_v_o        (mem_rd_w_v),
    .pc_w_v_o        (mem_pc_w_v),
    .rd_o            (mem_rd),
    .result_o        (mem_result),
    .target_o        (mem_target)
  );

  writeback_stage u_writeback_stage (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .mem_rd_w_v_i (mem_rd_w_v),
    .mem_pc_w_v_i (mem_pc_w_v),
    .mem_rd_i     (mem_rd),
    .mem_result_i (mem_result),
    .mem_target_i (mem_target),
    .rf_rd_w_v_o  (wb_rd_w_v),
    .rf_rd_o      (wb_rd),
    .rf_rd_data_o (wb_rd_data),
    .pc_w_v_o     (pc_w_v_o),
    .pc_target_o  (pc_target_o)
  );

  register_file u_register_file (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .w_v_i      (wb_rd_w_v),
    .w_rd_i     (wb_rd),
    .w_data_i   (wb_rd_data),
    .rs1_i      (rs1_i),
    .rs2_i      (rs2_i),
    .rs1_data_o (rs1_data_o),
    .rs2_data_o (rs2_data_o)
  );

  data_ram #(
    .RAM_WORDS   (RAM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) u_data_ram (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .wb_cyc_i (bus_cyc),
    .wb_stb_i (bus_stb),
    .wb_we_i  (bus_we),
    .wb_adr_i (bus_adr),
    .wb_sel_i (bus_sel),
    .wb_dat_i (bus_dat_w),
    .wb_ack_o (bus_ack),
    .wb_dat_o (bus_dat_r)
  );

endmodule : rvga_backend

`default_nettype wire

// File: source/data_ram.sv
`default_nettype none

module data_ram #(
  parameter int unsigned RAM_WORDS   = 256,
  parameter int unsigned WAIT_STATES = 1
) (
  input  wire logic                        clk,
  input  wire logic                        rst_n_i,

  input  wire logic                        wb_cyc_i,
  input  wire logic                        wb_stb_i,
  input  wire logic                        wb_we_i,
  input  wire logic [$clog2(RAM_WORDS)-1:0] wb_adr_i,
  input  wire logic [3:0]                  wb_sel_i,
  input  wire rvga_types_pkg::rvga_word    wb_dat_i,
  output logic                             wb_ack_o,
  output rvga_types_pkg::rvga_word         wb_dat_o
);

  import rvga_types_pkg::*;

  localparam int unsigned CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  rvga_word         mem [RAM_WORDS];
  logic [CNT_W-1:0] wait_cnt;
  logic             req;
  logic             ready;
  logic             fire;

  assign req   = wb_cyc_i && wb_stb_i;
  assign ready = (wait_cnt == CNT_W'(WAIT_STATES));
  // the ack is raised once per request, the master drops stb right after it
  assign fire  = req && !wb_ack_o && ready;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wait_cnt <= '0;
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= fire;
      if (!req || wb_ack_o) begin
        wait_cnt <= '0;
      end else if (!ready) begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      wb_dat_o <= mem[wb_adr_i];
    end
    if (wb_ack_o && req && wb_we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (wb_sel_i[b]) begin
          mem[wb_adr_i][b*8 +: 8] <= wb_dat_i[b*8 +: 8];
        end
      end
    end
  end

endmodule : data_ram

`default_nettype wire

// File: source/register_file.sv
`default_nettype none

module register_file (
  input  wire logic                     clk,
  input  wire logic                     rst_n_i,

  input  wire logic                     w_v_i,
  input  wire rvga_types_pkg::rvga_reg  w_rd_i,
  input  wire rvga_types_pkg::rvga_word w_data_i,

  input  wire rvga_types_pkg::rvga_reg  rs1_i,
  input  wire rvga_types_pkg::rvga_reg  rs2_i,
  output rvga_types_pkg::rvga_word      rs1_data_o,
  output rvga_types_pkg::rvga_word      rs2_data_o
);

  import rvga_types_pkg::*;

  // x0 has no storage, it is hardwired on the read side
  rvga_word regs [31:1];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (w_v_i && (w_rd_i != 5'd0)) begin
      regs[w_rd_i] <= w_data_i;
    end
  end

  ////////////////////////////////////////
  // read ports
  ////////////////////////////////////////

  always_comb begin
    rs1_data_o = '0;
    rs2_data_o = '0;
    if (rs1_i != 5'd0) begin
      rs1_data_o = regs[rs1_i];
    end
    if (rs2_i != 5'd0) begin
      rs2_data_o = regs[rs2_i];
    end
  end

endmodule : register_file

`default_nettype wire

// File: source/writeback_stage.sv
`default_nettype none

module writeback_stage (
  input  wire logic                     clk,
  input  wire logic                     rst_n_i,

  input  wire logic                     mem_rd_w_v_i,
  input  wire logic                     mem_pc_w_v_i,
  input  wire rvga_types_pkg::rvga_reg  mem_rd_i,
  input  wire rvga_types_pkg::rvga_word mem_result_i,
  input  wire rvga_types_pkg::rvga_word mem_target_i,

  output logic                          rf_rd_w_v_o,
  output rvga_types_pkg::rvga_reg       rf_rd_o,
  output rvga_types_pkg::rvga_word      rf_rd_data_o,
  output logic                          pc_w_v_o,
  output rvga_types_pkg::rvga_word      pc_target_o
);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rf_rd_w_v_o <= 1'b0;
      pc_w_v_o    <= 1'b0;
    end else begin
      // x0 writes die here so the register file never sees them
      rf_rd_w_v_o <= mem_rd_w_v_i && (mem_rd_i != 5'd0);
      pc_w_v_o    <= mem_pc_w_v_i;
    end
  end

  always_ff @(posedge clk) begin
    rf_rd_o      <= mem_rd_i;
    rf_rd_data_o <= mem_result_i;
    pc_target_o  <= mem_target_i;
  end

endmodule : writeback_stage

`default_nettype wire

// File: source/memory_stage.sv
`default_nettype none

module memory_stage #(
  parameter int unsigned RAM_WORDS = 256
) (
  input  wire logic                              clk,
  input  wire logic                              rst_n_i,

  input  wire logic                              ex_valid_i,
  input  wire rvga_mem_pkg::rvga_op              ex_op_i,
  input  wire rvga_mem_pkg::rvga_width           ex_width_i,
  input  wire rvga_types_pkg::rvga_reg           ex_rd_i,
  input  wire rvga_types_pkg::rvga_word          ex_result_i,
  input  wire rvga_types_pkg::rvga_word          ex_store_data_i,
  input  wire rvga_types_pkg::rvga_word          ex_link_i,
  output logic                                   ex_ready_o,

  output logic                                   wb_cyc_o,
  output logic                                   wb_stb_o,
  output logic                                   wb_we_o,
  output logic [$clog2(RAM_WORDS)-1:0]           wb_adr_o,
  output logic [3:0]                             wb_sel_o,
  output rvga_types_pkg::rvga_word               wb_dat_o,
  input  wire logic                              wb_ack_i,
  input  wire rvga_types_pkg::rvga_word          wb_dat_i,

  output logic                                   rd_w_v_o,
  output logic                                   pc_w_v_o,
  output rvga_types_pkg::rvga_reg                rd_o,
  output rvga_types_pkg::rvga_word               result_o,
  output rvga_types_pkg::rvga_word               target_o
);

  import rvga_types_pkg::*;
  import rvga_mem_pkg::*;

  localparam int unsigned ADR_W = $clog2(RAM_WORDS);

  logic       bus_open;
  logic       accept;
  logic       bus_done;
  rvga_width  ld_width;
  logic [1:0] ld_off;
  rvga_lanes  st_lanes;
  logic [3:0] st_sel;
  rvga_lanes  ld_lanes;
  logic [15:0] ld_half;
  rvga_word   ld_value;

  // a load or store blocks the next operation until the RAM acks
  assign ex_ready_o = !bus_open;
  assign accept     = ex_valid_i && ex_ready_o;
  assign bus_done   = bus_open && wb_ack_i;

  assign wb_cyc_o = bus_open;
  assign wb_stb_o = bus_open;

  ////////////////////////////////////////
  // store lane placement
  ////////////////////////////////////////

  always_comb begin
    st_lanes.word = ex_store_data_i;
    st_sel        = 4'b1111;
    case (ex_width_i)
      W_BYTE, W_BYTE_U: begin
        st_lanes.bytes = {4{ex_store_data_i[7:0]}};
        st_sel         = 4'b0001 << ex_result_i[1:0];
      end
      W_HALF, W_HALF_U: begin
        st_lanes.word = {2{ex_store_data_i[15:0]}};
        st_sel        = ex_result_i[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        st_sel = 4'b1111;
      end
    endcase
  end

  ////////////////////////////////////////
  // load lane select and extension
  ////////////////////////////////////////

  always_comb begin
    ld_lanes.word = wb_dat_i;
    ld_half       = ld_off[1] ? ld_lanes.bytes[3:2] : ld_lanes.bytes[1:0];
    case (ld_width)
      W_BYTE:   ld_value = {{24{ld_lanes.bytes[ld_off][7]}}, ld_lanes.bytes[ld_off]};
      W_BYTE_U: ld_value = {24'b0, ld_lanes.bytes[ld_off]};
      W_HALF:   ld_value = {{16{ld_half[15]}}, ld_half};
      W_HALF_U: ld_value = {16'b0, ld_half};
      default:  ld_value = ld_lanes.word;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bus_open <= 1'b0;
      rd_w_v_o <= 1'b0;
      pc_w_v_o <= 1'b0;
    end else begin
      rd_w_v_o <= 1'b0;
      pc_w_v_o <= 1'b0;
      if (accept) begin
        case (ex_op_i)
          OP_ALU: begin
            rd_w_v_o <= 1'b1;
          end
          OP_JUMP: begin
            rd_w_v_o <= 1'b1;
            pc_w_v_o <= 1'b1;
          end
          default: begin
            bus_open <= 1'b1;
          end
        endcase
      end else if (bus_done) begin
        bus_open <= 1'b0;
        // only loads write back, stores retire silently
        rd_w_v_o <= !wb_we_o;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rd_o     <= ex_rd_i;
      result_o <= (ex_op_i == OP_JUMP) ? ex_link_i : ex_result_i;
      target_o <= ex_result_i;
      wb_we_o  <= (ex_op_i == OP_STORE);
      wb_adr_o <= ex_result_i[ADR_W+1:2];
      wb_sel_o <= st_sel;
      wb_dat_o <= st_lanes.word;
      ld_width <= ex_width_i;
      ld_off   <= ex_result_i[1:0];
    end else if (bus_done) begin
      result_o <= ld_value;
    end
  end

endmodule : memory_stage

`default_nettype wire

// File: common/rvga_mem_pkg.sv
`default_nettype none

package rvga_mem_pkg;

  ////////////////////////////////////////
  // operation classes from execute
  ////////////////////////////////////////

  // alu writes the result to rd, jump writes the link value and redirects
  typedef enum logic [1:0] {
    OP_ALU   = 2'b00,
    OP_LOAD  = 2'b01,
    OP_STORE = 2'b10,
    OP_JUMP  = 2'b11
  } rvga_op;

  ////////////////////////////////////////
  // access widths, funct3 encoding
  ////////////////////////////////////////

  // bit 2 set means zero extension on loads, stores ignore it
  typedef enum logic [2:0] {
    W_BYTE   = 3'b000,
    W_HALF   = 3'b001,
    W_WORD   = 3'b010,
    W_BYTE_U = 3'b100,
    W_HALF_U = 3'b101
  } rvga_width;

endpackage : rvga_mem_pkg

`default_nettype wire

// File: common/rvga_types_pkg.sv
`default_nettype none

package rvga_types_pkg;

  ////////////////////////////////////////
  // basic datapath types
  ////////////////////////////////////////

  // one machine word, used for data, addresses and PC targets
  typedef logic [31:0] rvga_word;

  // architectural register index, x0 to x31
  typedef logic [4:0] rvga_reg;

  ////////////////////////////////////////
  // lane view of a bus word
  ////////////////////////////////////////

  // the same 32 bits read as one word or as four byte lanes,
  // lane 0 sits at the lowest byte address (little endian)
  typedef union packed {
    rvga_word        word;
    logic [3:0][7:0] bytes;
  } rvga_lanes;

endpackage : rvga_types_pkg

`default_nettype wire
